// ==== compile.f ====
+incdir+verilog
verilog/spu_isa_pkg.sv
verilog/spu_pipe_pkg.sv
verilog/spu_decode.sv
verilog/spu_regfile.sv
verilog/spu_permute.sv
verilog/spu_odd_pipe.sv
verif/spu_odd_pipe_properties.sv
verif/spu_odd_pipe_tb.sv

// ==== verif/permute_cases.txt ====
# mode(0 gap,1 chained,2 drain) load_a_addr load_a_value load_b_addr load_b_value
# instr squash exp_reg_write exp_rt exp_value, addr 80 means no load
2 01 81000000000000000000000000000003 02 00000000000000000000000000000000 3B608083 0 1 03 81000000000000000000000000000003
2 01 81000000000000000000000000000003 02 00000003000000000000000000000000 3B608083 0 1 03 08000000000000000000000000000018
2 01 81000000000000000000000000000003 02 00000007000000000000000000000000 3B608083 0 1 03 80000000000000000000000000000180
2 01 81000000000000000000000000000003 02 00000000000000000000000000000000 3B008083 0 1 03 81000000000000000000000000000003
2 01 81000000000000000000000000000003 02 00000003000000000000000000000000 3B008083 0 1 03 0800000000000000000000000000001c
2 01 81000000000000000000000000000003 02 00000007000000000000000000000000 3B008083 0 1 03 800000000000000000000000000001c0
2 01 0123456789abcdeffedcba9876543210 02 00000000000000000000000000000000 3BE08083 0 1 03 0123456789abcdeffedcba9876543210
2 01 0123456789abcdeffedcba9876543210 02 00000005000000000000000000000000 3BE08083 0 1 03 abcdeffedcba98765432100000000000
2 01 0123456789abcdeffedcba9876543210 02 0000000f000000000000000000000000 3BE08083 0 1 03 10000000000000000000000000000000
2 01 0123456789abcdeffedcba9876543210 02 00000010000000000000000000000000 3BE08083 0 1 03 00000000000000000000000000000000
2 01 0123456789abcdeffedcba9876543210 02 00000000000000000000000000000000 3B808083 0 1 03 0123456789abcdeffedcba9876543210
2 01 0123456789abcdeffedcba9876543210 02 00000005000000000000000000000000 3B808083 0 1 03 abcdeffedcba98765432100123456789
2 01 0123456789abcdeffedcba9876543210 02 0000000f000000000000000000000000 3B808083 0 1 03 100123456789abcdeffedcba98765432
2 01 0123456789abcdeffedcba9876543210 02 00000015000000000000000000000000 3B808083 0 1 03 abcdeffedcba98765432100123456789
2 01 81000000000000000000000000000003 80 0 3F7EC083 0 1 03 08000000000000000000000000000018
0 80 0 80 0 3F60C083 0 1 03 08000000000000000000000000000018
0 80 0 80 0 3F1FC083 0 1 03 800000000000000000000000000001c0
2 01 0123456789abcdeffedcba9876543210 80 0 3FF94083 0 1 03 abcdeffedcba98765432100000000000
0 80 0 80 0 3FE14083 0 1 03 abcdeffedcba98765432100000000000
0 80 0 80 0 3FE40083 0 1 03 00000000000000000000000000000000
0 80 0 80 0 3F9FC083 0 1 03 100123456789abcdeffedcba98765432
2 01 0123456789abcdeffedcba9876543210 02 00000005000000000000000000000000 36408083 0 1 03 0000ff00000000000000000000000000
1 80 0 80 0 36208084 0 1 04 000000f0000000000000000000000000
1 80 0 80 0 36008085 0 1 05 0000000c000000000000000000000000
1 80 0 80 0 3BE08086 0 1 06 abcdeffedcba98765432100000000000
1 80 0 80 0 3B808087 0 1 07 abcdeffedcba98765432100123456789
2 05 81000000000000000000000000000003 02 00000000000000000000000000000000 3B608085 1 0 05 0
0 80 0 80 0 00008085 0 0 05 0
0 80 0 80 0 FFE08085 0 0 05 0
2 80 0 80 0 3B608283 0 1 03 81000000000000000000000000000003
2 01 81000000000000000000000000000003 02 00000003000000000000000000000000 3B608086 0 1 06 08000000000000000000000000000018
2 80 0 02 00000004000000000000000000000000 3B608303 0 1 03 80000000000000000000000000000180

// ==== verif/spu_odd_pipe_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "spu_defines.svh"

module spu_odd_pipe_tb;

	localparam int max_cases = 64;
	localparam int clk_period = 40;
	localparam int reset_cycles = 10;
	// address value meaning no load in that column
	localparam logic [7:0] no_load = 8'h80;

	logic clk;
	logic reset;
	logic instr_valid;
	spu_isa_pkg::instr_word_u instr;
	logic branch_taken;
	spu_pipe_pkg::reg_load_t load;
	spu_pipe_pkg::wb_t wb;

	// case table from the data file
	int n_cases;
	int case_mode [max_cases];
	logic [7:0] load_a_addr [max_cases];
	logic [`SPU_QW_BITS-1:0] load_a_value [max_cases];
	logic [7:0] load_b_addr [max_cases];
	logic [`SPU_QW_BITS-1:0] load_b_value [max_cases];
	logic [`SPU_INSTR_BITS-1:0] case_instr [max_cases];
	logic case_squash [max_cases];
	logic case_we [max_cases];
	logic [7:0] case_rt [max_cases];
	logic [`SPU_QW_BITS-1:0] case_value [max_cases];
	logic test_failed [max_cases];
	logic cases_ready;

	// beats expected, oldest first
	int exp_test [$];
	logic [7:0] exp_rt [$];
	logic [`SPU_QW_BITS-1:0] exp_value [$];
	// tests with no beat, closed after a deadline
	int quiet_test [$];
	int quiet_deadline [$];

	int cycle;
	int idle;
	logic pending_squash;
	int pass_count;
	int fail_count;
	int stray_count;
	int chk_idx;
	logic [7:0] chk_rt;
	logic [`SPU_QW_BITS-1:0] chk_value;

	spu_odd_pipe i_dut (
		.clk(clk),
		.reset(reset),
		.instr_valid(instr_valid),
		.instr(instr),
		.branch_taken(branch_taken),
		.load(load),
		.wb(wb)
	);

	always #(clk_period / 2) clk = ~clk;

	task automatic report_test(input int idx);
		if (test_failed[idx]) begin
			fail_count++;
			$display("test %0d FAIL", idx);
		end
		else begin
			pass_count++;
			$display("test %0d ok", idx);
		end
	endtask

	task automatic read_cases();
		int fd;
		int n;
		string line;
		int f_mode;
		int f_sq;
		int f_we;
		logic [7:0] f_la;
		logic [7:0] f_lb;
		logic [7:0] f_rt;
		logic [`SPU_QW_BITS-1:0] f_va;
		logic [`SPU_QW_BITS-1:0] f_vb;
		logic [`SPU_QW_BITS-1:0] f_val;
		logic [`SPU_INSTR_BITS-1:0] f_instr;
		fd = $fopen("verif/permute_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open the case file verif/permute_cases.txt");
			return;
		end
		while (!$feof(fd) && n_cases < max_cases) begin
			n = $fgets(line, fd);
			if (n > 1 && line[0] != "#") begin
				n = $sscanf(line, "%d %h %h %h %h %h %d %d %h %h", f_mode, f_la, f_va,
					f_lb, f_vb, f_instr, f_sq, f_we, f_rt, f_val);
				if (n == 10) begin
					case_mode[n_cases] = f_mode;
					load_a_addr[n_cases] = f_la;
					load_a_value[n_cases] = f_va;
					load_b_addr[n_cases] = f_lb;
					load_b_value[n_cases] = f_vb;
					case_instr[n_cases] = f_instr;
					case_squash[n_cases] = (f_sq != 0);
					case_we[n_cases] = (f_we != 0);
					case_rt[n_cases] = f_rt;
					case_value[n_cases] = f_val;
					test_failed[n_cases] = 1'b0;
					n_cases++;
				end
				else begin
					$display("skipping a malformed case line: %s", line);
				end
			end
		end
		$fclose(fd);
	endtask

	// one falling edge, inputs back to idle
	task automatic next_cycle();
		@(negedge clk);
		instr_valid = 1'b0;
		load.valid = 1'b0;
		branch_taken = pending_squash;
		pending_squash = 1'b0;
		idle++;
	endtask

	task automatic drive_load(input logic [7:0] addr, input logic [`SPU_QW_BITS-1:0] value);
		next_cycle();
		load.valid = 1'b1;
		load.addr = addr[6:0];
		load.value = value;
	endtask

	task automatic run_case(input int t);
		int gap;
		// loads would lose against a writeback in flight
		if (case_mode[t] == 2 || load_a_addr[t] != no_load || load_b_addr[t] != no_load) begin
			while (idle < 6) begin
				next_cycle();
			end
		end
		else if (case_mode[t] == 0) begin
			gap = $urandom % 4;
			repeat (gap) begin
				next_cycle();
			end
		end
		if (load_a_addr[t] != no_load) begin
			drive_load(load_a_addr[t], load_a_value[t]);
		end
		if (load_b_addr[t] != no_load) begin
			drive_load(load_b_addr[t], load_b_value[t]);
		end
		next_cycle();
		instr_valid = 1'b1;
		instr = case_instr[t];
		idle = 0;
		// branch lands in the cycle this one sits in decode
		pending_squash = case_squash[t];
		if (case_we[t]) begin
			exp_test.push_back(t);
			exp_rt.push_back(case_rt[t]);
			exp_value.push_back(case_value[t]);
		end
		else begin
			quiet_test.push_back(t);
			quiet_deadline.push_back(cycle + 8);
		end
	endtask

	// wb is registered, stable at the falling edge
	always @(negedge clk) begin
		cycle = cycle + 1;
		if (!reset) begin
			if (wb.valid) begin
				if (exp_test.size() == 0) begin
					$display("unexpected writeback to register %0d with nothing pending",
						wb.rt_addr);
					stray_count++;
					if (quiet_test.size() > 0) begin
						test_failed[quiet_test[0]] = 1'b1;
					end
				end
				else begin
					chk_idx = exp_test.pop_front();
					chk_rt = exp_rt.pop_front();
					chk_value = exp_value.pop_front();
					if (wb.reg_write !== 1'b1) begin
						$display("ERROR test %0d wb.reg_write expected %h actual %h",
							chk_idx, 1'b1, wb.reg_write);
						test_failed[chk_idx] = 1'b1;
					end
					if (wb.rt_addr !== chk_rt[6:0]) begin
						$display("ERROR test %0d wb.rt_addr expected %h actual %h",
							chk_idx, chk_rt[6:0], wb.rt_addr);
						test_failed[chk_idx] = 1'b1;
					end
					if (wb.value !== chk_value) begin
						$display("ERROR test %0d wb.value expected %h actual %h",
							chk_idx, chk_value, wb.value);
						test_failed[chk_idx] = 1'b1;
					end
					report_test(chk_idx);
				end
			end
			while (quiet_test.size() > 0 && quiet_deadline[0] <= cycle) begin
				chk_idx = quiet_test.pop_front();
				void'(quiet_deadline.pop_front());
				report_test(chk_idx);
			end
		end
	end

	// budget grows with the number of cases
	initial begin
		wait (cases_ready);
		#((n_cases * 12 + reset_cycles) * clk_period);
		$display("watchdog expired before all tests finished");
		$display("Testbench failed");
		$finish;
	end

	initial begin
		void'($urandom(16487));
		clk = 1'b0;
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		branch_taken = 1'b0;
		load = '0;
		n_cases = 0;
		cases_ready = 1'b0;
		cycle = 0;
		idle = 100;
		pending_squash = 1'b0;
		pass_count = 0;
		fail_count = 0;
		stray_count = 0;
		read_cases();
		cases_ready = 1'b1;
		repeat (reset_cycles) @(negedge clk);
		reset = 1'b0;
		for (int t = 0; t < n_cases; t++) begin
			run_case(t);
		end
		// let the staging line and quiet deadlines run out
		while (idle < 12) begin
			next_cycle();
		end
		while (exp_test.size() > 0) begin
			chk_idx = exp_test.pop_front();
			void'(exp_rt.pop_front());
			void'(exp_value.pop_front());
			$display("test %0d expected a writeback that never arrived", chk_idx);
			test_failed[chk_idx] = 1'b1;
			report_test(chk_idx);
		end
		$display("%0d passed, %0d failed, %0d unexpected writebacks",
			pass_count, fail_count, stray_count);
		if (fail_count == 0 && stray_count == 0 && n_cases > 0) begin
			$display("Testbench passed");
		end
		else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/spu_odd_pipe_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

module spu_odd_pipe_properties (
	input logic clk,
	input logic reset,
	input logic instr_valid,
	input spu_isa_pkg::instr_word_u instr,
	input logic branch_taken,
	input spu_pipe_pkg::wb_t wb
);

	logic known_op;

	// ops that must come out of the staging line
	assign known_op = (spu_isa_pkg::op_format(instr.rr.op) != spu_isa_pkg::fmt_bad) &&
		(instr.rr.op != spu_isa_pkg::op_nop);

	// stages are cleared from the first reset edge on
	a_reset_quiet: assert property (@(posedge clk) reset && $past(reset) |-> !wb.valid)
		else $error("wb.valid high while reset is held");

	a_write_valid: assert property (@(posedge clk) disable iff (reset)
		wb.reg_write |-> wb.valid)
		else $error("wb.reg_write without wb.valid");

	// issue edge, branch window one cycle later, beat at the fixed writeback point
	a_latency: assert property (@(posedge clk) disable iff (reset)
		(instr_valid && known_op) ##1 !branch_taken |-> ##4 wb.valid)
		else $error("writeback beat missing at the fixed latency");

endmodule

bind spu_odd_pipe spu_odd_pipe_properties i_props (
	.clk(clk),
	.reset(reset),
	.instr_valid(instr_valid),
	.instr(instr),
	.branch_taken(branch_taken),
	.wb(wb)
);

`default_nettype wire

// ==== verilog/spu_odd_pipe.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "spu_defines.svh"

module spu_odd_pipe (
	input logic clk,
	input logic reset,
	input logic instr_valid,
	input spu_isa_pkg::instr_word_u instr,
	input logic branch_taken,
	input spu_pipe_pkg::reg_load_t load,
	output spu_pipe_pkg::wb_t wb
);

	spu_pipe_pkg::issue_t iss;
	logic [0:`SPU_QW_BITS-1] ra;
	logic [0:`SPU_QW_BITS-1] rb;

	// decode, one register stage
	spu_decode i_decode (
		.clk(clk),
		.reset(reset),
		.instr_valid(instr_valid),
		.instr(instr),
		.branch_taken(branch_taken),
		.iss(iss)
	);

	// operands read straight off the decoded addresses
	spu_regfile i_regfile (
		.clk(clk),
		.reset(reset),
		.ra_addr(iss.ra_addr),
		.rb_addr(iss.rb_addr),
		.ra(ra),
		.rb(rb),
		.wb(wb),
		.load(load)
	);

	// execute and delay to writeback
	spu_permute i_permute (
		.clk(clk),
		.reset(reset),
		.iss(iss),
		.ra(ra),
		.rb(rb),
		.wb(wb)
	);

endmodule

`default_nettype wire

// ==== verilog/spu_permute.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "spu_defines.svh"

module spu_permute (
	input logic clk,
	input logic reset,
	input spu_pipe_pkg::issue_t iss,
	input logic [0:`SPU_QW_BITS-1] ra,
	input logic [0:`SPU_QW_BITS-1] rb,
	output spu_pipe_pkg::wb_t wb
);

	localparam int depth = `SPU_PERM_DEPTH;
	localparam int qw_bits = `SPU_QW_BITS;

	spu_pipe_pkg::wb_t stage [0:depth-1];
	spu_pipe_pkg::wb_t result;
	logic [0:2] bit_cnt;
	logic [0:4] byte_cnt;
	logic [0:qw_bits-1] value;
	logic known;

	// left is toward bit 0, wrap the top bits back in at the bottom
	function automatic logic [0:qw_bits-1] rotl(
		input logic [0:qw_bits-1] qw,
		input logic [7:0] amt
	);
		return (qw << amt) | (qw >> (qw_bits - amt));
	endfunction

	// counts come from rb for rr forms, masked i7 for immediates
	always_comb begin
		if (iss.format == spu_isa_pkg::fmt_ri7) begin
			bit_cnt = iss.imm[4:6];
			byte_cnt = iss.imm[2:6];
		end
		else begin
			bit_cnt = rb[29:31];
			byte_cnt = rb[27:31];
		end
	end

	always_comb begin
		value = '0;
		known = 1'b1;
		case (iss.op)
			spu_isa_pkg::op_shlqbi, spu_isa_pkg::op_shlqbii: begin
				value = ra << bit_cnt;
			end
			spu_isa_pkg::op_shlqby, spu_isa_pkg::op_shlqbyi: begin
				// 16 bytes or more shifts everything out
				value = ra << {byte_cnt, 3'b000};
			end
			spu_isa_pkg::op_rotqbi, spu_isa_pkg::op_rotqbii: begin
				value = rotl(ra, {5'b00000, bit_cnt});
			end
			spu_isa_pkg::op_rotqby, spu_isa_pkg::op_rotqbyi: begin
				// only 4 bits of count for a 16 byte rotate
				value = rotl(ra, {1'b0, byte_cnt[1:4], 3'b000});
			end
			spu_isa_pkg::op_gbb: begin
				// lsb of each byte into word 0 bits 16..31
				for (int k = 0; k < 16; k++) begin
					value[16 + k] = ra[8 * k + 7];
				end
			end
			spu_isa_pkg::op_gbh: begin
				for (int k = 0; k < 8; k++) begin
					value[24 + k] = ra[16 * k + 15];
				end
			end
			spu_isa_pkg::op_gb: begin
				for (int k = 0; k < 4; k++) begin
					value[28 + k] = ra[32 * k + 31];
				end
			end
			default: begin
				// nop lands here too
				known = 1'b0;
			end
		endcase
	end

	// stage 0 beat
	always_comb begin
		result.valid = iss.valid && known && (iss.format != spu_isa_pkg::fmt_bad);
		// write enable as decoded, squash already cleared it
		result.reg_write = iss.reg_write;
		result.rt_addr = iss.rt_addr;
		result.value = value;
	end

	// fixed latency delay line, no stalls
	always_ff @(posedge clk) begin
		stage[0] <= result;
		for (int i = 1; i < depth; i++) begin
			stage[i] <= stage[i - 1];
		end
		if (reset) begin
			for (int i = 0; i < depth; i++) begin
				stage[i].valid <= 1'b0;
				stage[i].reg_write <= 1'b0;
			end
		end
	end

	// writeback point
	assign wb = stage[depth - 1];

endmodule

`default_nettype wire

// ==== verilog/spu_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "spu_defines.svh"

module spu_regfile (
	input logic clk,
	input logic reset,
	input logic [0:`SPU_REG_ADDR_BITS-1] ra_addr,
	input logic [0:`SPU_REG_ADDR_BITS-1] rb_addr,
	output logic [0:`SPU_QW_BITS-1] ra,
	output logic [0:`SPU_QW_BITS-1] rb,
	input spu_pipe_pkg::wb_t wb,
	input spu_pipe_pkg::reg_load_t load
);

	localparam int num_regs = 2 ** `SPU_REG_ADDR_BITS;

	logic [0:`SPU_QW_BITS-1] regs [0:num_regs-1];
	logic wb_write;

	// writeback owns the port when both want it
	assign wb_write = wb.valid && wb.reg_write;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end
		else if (wb_write) begin
			regs[wb.rt_addr] <= wb.value;
		end
		else if (load.valid) begin
			// load dropped on a collision
			regs[load.addr] <= load.value;
		end
	end

	// async read, no bypass of same-cycle writes
	assign ra = regs[ra_addr];
	assign rb = regs[rb_addr];

endmodule

`default_nettype wire

// ==== verilog/spu_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module spu_decode (
	input logic clk,
	input logic reset,
	input logic instr_valid,
	input spu_isa_pkg::instr_word_u instr,
	input logic branch_taken,
	output spu_pipe_pkg::issue_t iss
);

	spu_isa_pkg::instr_format_t fmt;
	spu_pipe_pkg::issue_t dec;
	spu_pipe_pkg::issue_t dec_q;

	// split fields, format picks which view of the word is meaningful
	always_comb begin
		fmt = spu_isa_pkg::op_format(instr.rr.op);
		dec = '0;
		dec.valid = instr_valid;
		dec.op = instr.rr.op;
		dec.format = fmt;
		case (fmt)
			spu_isa_pkg::fmt_rr: begin
				dec.rt_addr = instr.rr.rt;
				dec.ra_addr = instr.rr.ra;
				dec.rb_addr = instr.rr.rb;
			end
			spu_isa_pkg::fmt_ri7: begin
				dec.rt_addr = instr.ri7.rt;
				dec.ra_addr = instr.ri7.ra;
				// immediate sits where rb would be
				dec.imm = instr.ri7.i7;
			end
			default: begin
				// unknown op, fields left at zero
				dec.rt_addr = '0;
			end
		endcase
		// nop and unknown ops never write
		dec.reg_write = instr_valid && (fmt != spu_isa_pkg::fmt_bad) &&
			(instr.rr.op != spu_isa_pkg::op_nop);
	end

	// decode register
	always_ff @(posedge clk) begin
		dec_q <= dec;
		if (reset) begin
			dec_q.valid <= 1'b0;
			dec_q.reg_write <= 1'b0;
		end
	end

	// taken branch kills whatever sits in decode this cycle
	always_comb begin
		iss = dec_q;
		if (branch_taken) begin
			iss.valid = 1'b0;
			iss.reg_write = 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/spu_pipe_pkg.sv ====
`default_nettype none

`include "spu_defines.svh"

package spu_pipe_pkg;

	// decode to permute
	typedef struct packed {
		logic valid;
		logic [0:spu_isa_pkg::op_bits-1] op;
		spu_isa_pkg::instr_format_t format;
		logic [0:`SPU_REG_ADDR_BITS-1] rt_addr;
		logic [0:`SPU_REG_ADDR_BITS-1] ra_addr;
		logic [0:`SPU_REG_ADDR_BITS-1] rb_addr;
		logic [0:spu_isa_pkg::i7_bits-1] imm;
		logic reg_write;
	} issue_t;

	// one beat of the staging line, last stage is the writeback
	typedef struct packed {
		logic valid;
		logic reg_write;
		logic [0:`SPU_REG_ADDR_BITS-1] rt_addr;
		logic [0:`SPU_QW_BITS-1] value;
	} wb_t;

	// stand-in for the load/store path
	typedef struct packed {
		logic valid;
		logic [0:`SPU_REG_ADDR_BITS-1] addr;
		logic [0:`SPU_QW_BITS-1] value;
	} reg_load_t;

endpackage

`default_nettype wire

// ==== verilog/spu_isa_pkg.sv ====
`default_nettype none

`include "spu_defines.svh"

package spu_isa_pkg;

	localparam int addr_bits = `SPU_REG_ADDR_BITS;
	// whatever is left after the three register fields
	localparam int op_bits = `SPU_INSTR_BITS - 3 * addr_bits;
	localparam int i7_bits = 7;

	typedef enum logic [1:0] {
		fmt_rr = 2'd0,
		fmt_ri7 = 2'd2,
		fmt_bad = 2'd3
	} instr_format_t;

	// rr form, odd pipe permutes
	localparam logic [0:op_bits-1] op_nop = 11'b00000000000;
	localparam logic [0:op_bits-1] op_shlqbi = 11'b00111011011;
	localparam logic [0:op_bits-1] op_shlqby = 11'b00111011111;
	localparam logic [0:op_bits-1] op_rotqbi = 11'b00111011000;
	localparam logic [0:op_bits-1] op_rotqby = 11'b00111011100;
	localparam logic [0:op_bits-1] op_gbb = 11'b00110110010;
	localparam logic [0:op_bits-1] op_gbh = 11'b00110110001;
	localparam logic [0:op_bits-1] op_gb = 11'b00110110000;
	// ri7 form
	localparam logic [0:op_bits-1] op_shlqbii = 11'b00111111011;
	localparam logic [0:op_bits-1] op_shlqbyi = 11'b00111111111;
	localparam logic [0:op_bits-1] op_rotqbii = 11'b00111111000;
	localparam logic [0:op_bits-1] op_rotqbyi = 11'b00111111100;

	typedef struct packed {
		logic [0:op_bits-1] op;
		logic [0:addr_bits-1] rb;
		logic [0:addr_bits-1] ra;
		logic [0:addr_bits-1] rt;
	} rr_fields_t;

	typedef struct packed {
		logic [0:op_bits-1] op;
		logic [0:i7_bits-1] i7;
		logic [0:addr_bits-1] ra;
		logic [0:addr_bits-1] rt;
	} ri7_fields_t;

	// same 32 bits, rb slot doubles as the immediate
	typedef union packed {
		rr_fields_t rr;
		ri7_fields_t ri7;
	} instr_word_u;

	function automatic instr_format_t op_format(input logic [0:op_bits-1] op);
		case (op)
			op_nop, op_shlqbi, op_shlqby, op_rotqbi, op_rotqby,
			op_gbb, op_gbh, op_gb: return fmt_rr;
			op_shlqbii, op_shlqbyi, op_rotqbii, op_rotqbyi: return fmt_ri7;
			default: return fmt_bad;
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== verilog/spu_defines.svh ====
`ifndef SPU_DEFINES_SVH
`define SPU_DEFINES_SVH

// quadword register width, bit 0 is the msb
`define SPU_QW_BITS 128

// 128 registers in the file
`define SPU_REG_ADDR_BITS 7

// one instruction word
`define SPU_INSTR_BITS 32

// stages between issue and writeback in the permute unit
`define SPU_PERM_DEPTH 4

`endif
